// ==== project.f ====
verilog/traceCfgPkg.sv
verilog/traceTypesPkg.sv
verilog/traceRecordIf.sv
verilog/sampleWindow.sv
verilog/traceConfig.sv
verilog/eventCounters.sv
verilog/traceEncoder.sv
verilog/traceBuffer.sv
verilog/perfTraceTop.sv
dv/tbClock.sv
dv/perfTraceTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the trace unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module perfTraceTb -f project.f

output=$(./obj_dir/VperfTraceTb)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'Simulation finished: PASS'; then
  exit 0
fi
exit 1

// ==== dv/perfTraceTb.sv ====
// self-checking testbench for the trace unit and the top module of its simulation
`timescale 1ns/100ps

module perfTraceTb;
  import traceCfgPkg::*;
  import traceTypesPkg::*;

  localparam int EVENTS = 8;
  localparam int DEPTH = 16;

  // one trace record as the reference model predicts it
  typedef struct packed {
    recKindE kind;
    addrT addr;
    cacheOpE op;
    outcomeE outcome;
    logic taken;
  } recT;

  logic clk;
  logic resetEdge;
  logic startTrigger;
  logic endTrigger;
  logic cacheAccess;
  addrT cacheAddr;
  cacheOpE cacheOp;
  logic cacheHit;
  logic cacheAllValid;
  logic cacheDirty;
  logic retireValid;
  instrClassT instrClass;
  addrT retirePc;
  logic branchTaken;
  logic [EVENTS-1:0] events;
  logic cfgWrite;
  cfgAddrT cfgAddr;
  countT cfgWdata;
  countT cfgRdata;
  logic recRead;
  logic recValid;
  recKindE recKind;
  addrT recAddr;
  cacheOpE recOp;
  outcomeE recOutcome;
  logic recTaken;

  recT expQ [$];
  int errors;
  int checks;
  bit timedOut;
  bit drainOn;

  // reference model state
  bit prevStart;
  bit prevEnd;
  bit modelWindow;
  bit modelCacheEn;
  bit modelBranchEn;
  bit modelCfi;
  runTagT modelTag;
  bit counting;
  countT refCount [EVENTS];
  countT refDelta [EVENTS];

  tbClock u_tbClock (
    .clk(clk),
    .resetEdge(resetEdge)
  );

  perfTraceTop #(.NUM_EVENTS(EVENTS), .TRACE_DEPTH(DEPTH)) u_perfTraceTop (
    .clk(clk),
    .resetEdge(resetEdge),
    .startTrigger(startTrigger),
    .endTrigger(endTrigger),
    .cacheAccess(cacheAccess),
    .cacheAddr(cacheAddr),
    .cacheOp(cacheOp),
    .cacheHit(cacheHit),
    .cacheAllValid(cacheAllValid),
    .cacheDirty(cacheDirty),
    .retireValid(retireValid),
    .instrClass(instrClass),
    .retirePc(retirePc),
    .branchTaken(branchTaken),
    .events(events),
    .cfgWrite(cfgWrite),
    .cfgAddr(cfgAddr),
    .cfgWdata(cfgWdata),
    .cfgRdata(cfgRdata),
    .recRead(recRead),
    .recValid(recValid),
    .recKind(recKind),
    .recAddr(recAddr),
    .recOp(recOp),
    .recOutcome(recOutcome),
    .recTaken(recTaken)
  );

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // hit first, then empty way, then dirty or clean victim
  // flush has no outcome
  function automatic outcomeE expectOutcome(cacheOpE op, logic hit, logic allValid, logic dirty);
    outcomeE o;
    if (op == OP_FLUSH)
      o = OUT_NONE;
    else if (hit)
      o = OUT_HIT;
    else if (!allValid)
      o = OUT_MISS;
    else if (dirty)
      o = OUT_EVICT_DIRTY;
    else
      o = OUT_EVICT_CLEAN;
    return o;
  endfunction

  // record expected for this cycle's inputs
  // priority order END then BEGIN then CACHE then BRANCH
  function automatic bit predictRecord(input bit startP, input bit endP, output recT r);
    bit branchSel;
    bit found;
    r = '0;
    found = 1'b1;
    branchSel = modelCfi ? (instrClass != 2'b00) : instrClass[0];
    if (endP) begin
      r.kind = REC_END;
      r.addr = addrT'(modelTag);
    end else if (startP) begin
      r.kind = REC_BEGIN;
      r.addr = addrT'(modelTag);
    end else if (modelCacheEn && modelWindow && cacheAccess) begin
      r.kind = REC_CACHE;
      r.addr = cacheAddr;
      r.op = cacheOp;
      r.outcome = expectOutcome(cacheOp, cacheHit, cacheAllValid, cacheDirty);
    end else if (modelBranchEn && modelWindow && retireValid && branchSel) begin
      r.kind = REC_BRANCH;
      r.addr = retirePc;
      r.taken = branchTaken;
    end else begin
      found = 1'b0;
    end
    return found;
  endfunction

  // event cycles from the start cycle up to the cycle before the end cycle
  function automatic void countEvents(bit startP, bit endP);
    if (endP) begin
      counting = 1'b0;
      for (int i = 0; i < EVENTS; i++)
        refDelta[i] = refCount[i];
    end else begin
      if (startP) begin
        counting = 1'b1;
        for (int i = 0; i < EVENTS; i++)
          refCount[i] = '0;
      end
      if (counting) begin
        for (int i = 0; i < EVENTS; i++)
          refCount[i] = refCount[i] + countT'(events[i]);
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // drive and check helpers
  ////////////////////////////////////////////////////////////

  task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // ends the current cycle through the model, then moves 2 ns past the next edge
  task automatic advance();
    bit startP;
    bit endP;
    recT r;
    startP = startTrigger && !prevStart;
    endP = endTrigger && !prevEnd;
    if (predictRecord(startP, endP, r))
      expQ.push_back(r);
    countEvents(startP, endP);
    if (endP)
      modelWindow = 1'b0;
    else if (startP)
      modelWindow = 1'b1;
    // config writes land at this edge
    if (cfgWrite && cfgAddr == CFG_CTRL) begin
      modelCacheEn = cfgWdata[CTRL_CACHE_EN];
      modelBranchEn = cfgWdata[CTRL_BRANCH_EN];
      modelCfi = cfgWdata[CTRL_CFI_MODE];
    end
    if (cfgWrite && cfgAddr == CFG_TAG)
      modelTag = runTagT'(cfgWdata);
    prevStart = startTrigger;
    prevEnd = endTrigger;
    @(posedge clk);
    #2;
    // strobes last one cycle
    startTrigger = 1'b0;
    endTrigger = 1'b0;
    cacheAccess = 1'b0;
    retireValid = 1'b0;
    cfgWrite = 1'b0;
    events = '0;
  endtask

  task automatic writeCfg(input cfgAddrT a, input countT d);
    cfgWrite = 1'b1;
    cfgAddr = a;
    cfgWdata = d;
    advance();
  endtask

  // read path is combinational and sampled 1 ns after the address
  task automatic readCfg(input cfgAddrT a, output countT d);
    cfgAddr = a;
    #1;
    d = cfgRdata;
    advance();
  endtask

  task automatic randomAccess();
    cacheAccess = 1'b1;
    cacheAddr = $urandom;
    cacheOp = cacheOpE'($urandom_range(3, 0));
    cacheHit = 1'($urandom_range(1, 0));
    cacheAllValid = 1'($urandom_range(1, 0));
    cacheDirty = 1'($urandom_range(1, 0));
  endtask

  // random retirements with about a quarter of the cycles idle
  task automatic branchBurst(input int n);
    repeat (n) begin
      retireValid = ($urandom_range(3, 0) != 0);
      instrClass = instrClassT'($urandom_range(3, 0));
      retirePc = {30'($urandom_range(32'h3fff_ffff, 0)), 2'b00};
      branchTaken = 1'($urandom_range(1, 0));
      advance();
    end
  endtask

  // waits until every predicted record came out and the buffer is empty
  task automatic waitDrained(input int maxCycles, output bit ok);
    int n;
    ok = 1'b0;
    n = 0;
    while (!ok && n < maxCycles) begin
      if (expQ.size() == 0 && !recValid)
        ok = 1'b1;
      else
        advance();
      n++;
    end
    if (!ok) begin
      timedOut = 1'b1;
      $display("Timeout: %0d expected records never came out of the trace buffer", expQ.size());
    end
  endtask

  task automatic compareHead();
    recT e;
    if (expQ.size() == 0) begin
      errors++;
      $display("Unexpected record of kind %s came out at %0t ns", recKind.name(), $time);
      return;
    end
    e = expQ.pop_front();
    checkValue("record kind", 32'(recKind), 32'(e.kind));
    checkValue("record addr", recAddr, e.addr);
    checkValue("record taken", 32'(recTaken), 32'(e.taken));
    if (e.kind == REC_CACHE) begin
      checkValue("cache op", 32'(recOp), 32'(e.op));
      checkValue("cache outcome", 32'(recOutcome), 32'(e.outcome));
    end
  endtask

  task automatic reportTest(input string name, input int errBefore);
    if (errors == errBefore)
      $display("%s: done, no errors", name);
    else
      $display("%s: done, %0d errors", name, errors - errBefore);
  endtask

  ////////////////////////////////////////////////////////////
  // drain process
  ////////////////////////////////////////////////////////////

  // pops one record per cycle while the pause flag sampled at the edge allows it
  initial begin : drainer
    bit doDrain;
    forever begin
      @(posedge clk);
      doDrain = drainOn;
      #2;
      if (doDrain && recValid) begin
        compareHead();
        recRead = 1'b1;
      end else begin
        recRead = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic resetAndTrain();
    int n;
    int errBefore;
    bit ok;
    countT d;
    errBefore = errors;
    expQ.push_back('{kind: REC_TRAIN, addr: '0, op: OP_READ, outcome: OUT_HIT, taken: 1'b0});
    n = 0;
    do begin
      @(posedge clk);
      #2;
      n++;
    end while (resetEdge && n < 20);
    if (resetEdge) begin
      timedOut = 1'b1;
      $display("Timeout: reset never went low");
      return;
    end
    checkValue("recValid after reset", 32'(recValid), 32'd0);
    readCfg(CFG_CTRL, d);
    checkValue("CTRL after reset", d, 32'd0);
    waitDrained(20, ok);
    if (ok)
      reportTest("reset and train", errBefore);
  endtask

  task automatic cacheTrace();
    int errBefore;
    bit ok;
    errBefore = errors;
    writeCfg(CFG_TAG, 32'h0000_5a17);
    writeCfg(CFG_CTRL, 32'h1);
    // nothing is traced while the window is closed
    repeat (5) begin
      randomAccess();
      advance();
    end
    startTrigger = 1'b1;
    advance();
    for (int i = 0; i < 40; i++) begin
      randomAccess();
      advance();
      repeat ($urandom_range(2, 0)) advance();
    end
    endTrigger = 1'b1;
    advance();
    waitDrained(100, ok);
    if (ok)
      reportTest("cache classification", errBefore);
  endtask

  task automatic branchTrace();
    int errBefore;
    bit ok;
    errBefore = errors;
    writeCfg(CFG_TAG, 32'h0000_b7a2);
    writeCfg(CFG_CTRL, 32'h2);
    branchBurst(10);
    // conditional branches only
    startTrigger = 1'b1;
    advance();
    branchBurst(30);
    endTrigger = 1'b1;
    advance();
    // every control transfer
    writeCfg(CFG_CTRL, 32'h6);
    startTrigger = 1'b1;
    advance();
    branchBurst(30);
    endTrigger = 1'b1;
    advance();
    // only markers while both enables are clear
    writeCfg(CFG_CTRL, 32'h0);
    startTrigger = 1'b1;
    advance();
    branchBurst(20);
    endTrigger = 1'b1;
    advance();
    waitDrained(100, ok);
    if (ok)
      reportTest("branch and cfi filtering", errBefore);
  endtask

  task automatic counterDeltas();
    int errBefore;
    bit ok;
    countT d;
    errBefore = errors;
    repeat (5) begin
      events = EVENTS'($urandom);
      advance();
    end
    startTrigger = 1'b1;
    events = EVENTS'($urandom);
    advance();
    repeat (25) begin
      events = EVENTS'($urandom);
      advance();
    end
    // the end cycle's events fall outside the delta
    endTrigger = 1'b1;
    events = EVENTS'($urandom);
    advance();
    repeat (3) begin
      events = EVENTS'($urandom);
      advance();
    end
    for (int i = 0; i < EVENTS; i++) begin
      readCfg(cfgAddrT'(int'(CFG_CNT_BASE) + i), d);
      checkValue($sformatf("delta %0d", i), d, refDelta[i]);
    end
    waitDrained(50, ok);
    if (ok)
      reportTest("counter deltas", errBefore);
  endtask

  task automatic overflowAndPriority();
    int errBefore;
    int excess;
    bit ok;
    countT drop0;
    countT drop1;
    errBefore = errors;
    // the buffer was drained every cycle so far and never filled
    readCfg(CFG_DROP, drop0);
    checkValue("drop count before overflow", drop0, 32'd0);
    writeCfg(CFG_CTRL, 32'h1);
    drainOn = 1'b0;
    advance();
    startTrigger = 1'b1;
    advance();
    repeat (DEPTH + 4) begin
      randomAccess();
      advance();
    end
    // the buffer started empty so only the oldest DEPTH records stay
    excess = expQ.size() - DEPTH;
    while (expQ.size() > DEPTH)
      void'(expQ.pop_back());
    // last record reaches the buffer two cycles after its input
    advance();
    advance();
    readCfg(CFG_DROP, drop1);
    checkValue("drop count", drop1, countT'(excess));
    drainOn = 1'b1;
    waitDrained(100, ok);
    if (!ok)
      return;
    // end marker beats a cache access in the same cycle
    endTrigger = 1'b1;
    randomAccess();
    advance();
    waitDrained(20, ok);
    if (ok)
      reportTest("overflow and priority", errBefore);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    void'($urandom(32'h12c856e5));
    startTrigger = 1'b0;
    endTrigger = 1'b0;
    cacheAccess = 1'b0;
    cacheAddr = '0;
    cacheOp = OP_READ;
    cacheHit = 1'b0;
    cacheAllValid = 1'b0;
    cacheDirty = 1'b0;
    retireValid = 1'b0;
    instrClass = '0;
    retirePc = '0;
    branchTaken = 1'b0;
    events = '0;
    cfgWrite = 1'b0;
    cfgAddr = '0;
    cfgWdata = '0;
    recRead = 1'b0;
    errors = 0;
    checks = 0;
    timedOut = 1'b0;
    drainOn = 1'b1;
    // trigger delays leave reset high
    prevStart = 1'b1;
    prevEnd = 1'b1;
    modelWindow = 1'b0;
    modelCacheEn = 1'b0;
    modelBranchEn = 1'b0;
    modelCfi = 1'b0;
    modelTag = '0;
    counting = 1'b0;
    for (int i = 0; i < EVENTS; i++) begin
      refCount[i] = '0;
      refDelta[i] = '0;
    end

    resetAndTrain();
    if (!timedOut)
      cacheTrace();
    if (!timedOut)
      branchTrace();
    if (!timedOut)
      counterDeltas();
    if (!timedOut)
      overflowAndPriority();

    $display("checks %0d, errors %0d, timeout %0d", checks, errors, timedOut);
    if (errors == 0 && !timedOut)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== dv/tbClock.sv ====
// clock and synchronous reset source for the trace unit testbench
`timescale 1ns/100ps

module tbClock #(
  parameter int HALF_NS = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic resetEdge
);

  // 40 ns period with the default half period
  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  // reset released 2 ns after an edge, like every other input
  initial begin
    resetEdge = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    resetEdge = 1'b0;
  end

endmodule

// ==== verilog/perfTraceTop.sv ====
// performance sampling and trace unit, driven from the core's trigger, cache and retire ports
`timescale 1ns/100ps

module perfTraceTop #(
  parameter int NUM_EVENTS = traceCfgPkg::NUM_EVENTS,
  parameter int TRACE_DEPTH = traceCfgPkg::TRACE_DEPTH
) (
  input logic clk,
  input logic resetEdge,
  // window triggers
  input logic startTrigger,
  input logic endTrigger,
  // generic cache access port
  input logic cacheAccess,
  input traceCfgPkg::addrT cacheAddr,
  input traceTypesPkg::cacheOpE cacheOp,
  input logic cacheHit,
  input logic cacheAllValid,
  input logic cacheDirty,
  // retirement, taken already aligned
  input logic retireValid,
  input traceTypesPkg::instrClassT instrClass,
  input traceCfgPkg::addrT retirePc,
  input logic branchTaken,
  input logic [NUM_EVENTS-1:0] events,
  // config port
  input logic cfgWrite,
  input traceCfgPkg::cfgAddrT cfgAddr,
  input traceCfgPkg::countT cfgWdata,
  output traceCfgPkg::countT cfgRdata,
  // trace output, pop with recRead while recValid
  input logic recRead,
  output logic recValid,
  output traceTypesPkg::recKindE recKind,
  output traceCfgPkg::addrT recAddr,
  output traceTypesPkg::cacheOpE recOp,
  output traceTypesPkg::outcomeE recOutcome,
  output logic recTaken
);
  import traceCfgPkg::*;

  logic startPulse;
  logic endPulse;
  logic trainPulse;
  logic inWindow;
  logic cacheEn;
  logic branchEn;
  logic cfiMode;
  runTagT runTag;
  countT deltas [NUM_EVENTS];
  countT dropCount;

  traceRecordIf recIf ();

  sampleWindow u_sampleWindow (
    .clk(clk),
    .resetEdge(resetEdge),
    .startTrigger(startTrigger),
    .endTrigger(endTrigger),
    .startPulse(startPulse),
    .endPulse(endPulse),
    .trainPulse(trainPulse),
    .inWindow(inWindow)
  );

  traceConfig #(.NUM_EVENTS(NUM_EVENTS)) u_traceConfig (
    .clk(clk),
    .resetEdge(resetEdge),
    .cfgWrite(cfgWrite),
    .cfgAddr(cfgAddr),
    .cfgWdata(cfgWdata),
    .deltas(deltas),
    .dropCount(dropCount),
    .cfgRdata(cfgRdata),
    .cacheEn(cacheEn),
    .branchEn(branchEn),
    .cfiMode(cfiMode),
    .runTag(runTag)
  );

  eventCounters #(.NUM_EVENTS(NUM_EVENTS)) u_eventCounters (
    .clk(clk),
    .resetEdge(resetEdge),
    .events(events),
    .startPulse(startPulse),
    .endPulse(endPulse),
    .deltas(deltas)
  );

  traceEncoder u_traceEncoder (
    .clk(clk),
    .resetEdge(resetEdge),
    .trainPulse(trainPulse),
    .startPulse(startPulse),
    .endPulse(endPulse),
    .inWindow(inWindow),
    .cacheEn(cacheEn),
    .branchEn(branchEn),
    .cfiMode(cfiMode),
    .runTag(runTag),
    .cacheAccess(cacheAccess),
    .cacheAddr(cacheAddr),
    .cacheOp(cacheOp),
    .cacheHit(cacheHit),
    .cacheAllValid(cacheAllValid),
    .cacheDirty(cacheDirty),
    .retireValid(retireValid),
    .instrClass(instrClass),
    .retirePc(retirePc),
    .branchTaken(branchTaken),
    .rec(recIf.src)
  );

  traceBuffer #(.TRACE_DEPTH(TRACE_DEPTH)) u_traceBuffer (
    .clk(clk),
    .resetEdge(resetEdge),
    .rec(recIf.dst),
    .recRead(recRead),
    .recValid(recValid),
    .recKind(recKind),
    .recAddr(recAddr),
    .recOp(recOp),
    .recOutcome(recOutcome),
    .recTaken(recTaken),
    .dropCount(dropCount)
  );

endmodule

// ==== verilog/traceBuffer.sv ====
// first-word-fall-through record queue drained by a read strobe, counts records lost when full
`timescale 1ns/100ps

module traceBuffer #(
  parameter int TRACE_DEPTH = traceCfgPkg::TRACE_DEPTH
) (
  input logic clk,
  input logic resetEdge,
  traceRecordIf.dst rec,
  input logic recRead,
  output logic recValid,
  output traceTypesPkg::recKindE recKind,
  output traceCfgPkg::addrT recAddr,
  output traceTypesPkg::cacheOpE recOp,
  output traceTypesPkg::outcomeE recOutcome,
  output logic recTaken,
  output traceCfgPkg::countT dropCount
);
  import traceCfgPkg::*;
  import traceTypesPkg::*;

  localparam int PTR_W = (TRACE_DEPTH > 1) ? $clog2(TRACE_DEPTH) : 1;
  localparam int CNT_W = $clog2(TRACE_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(TRACE_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(TRACE_DEPTH);

  // one storage array per record field
  recKindE kindMem [TRACE_DEPTH];
  addrT addrMem [TRACE_DEPTH];
  cacheOpE opMem [TRACE_DEPTH];
  outcomeE outcomeMem [TRACE_DEPTH];
  logic takenMem [TRACE_DEPTH];

  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] occupancy;
  logic full;
  logic doRead;
  logic doWrite;

  assign full = (occupancy == FULL_CNT);
  assign doRead = recRead & recValid;
  // a pop in the same cycle frees the slot for a full queue
  assign doWrite = rec.valid & (~full | doRead);

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (doWrite) begin
      kindMem[wrPtr] <= rec.kind;
      addrMem[wrPtr] <= rec.addr;
      opMem[wrPtr] <= rec.op;
      outcomeMem[wrPtr] <= rec.outcome;
      takenMem[wrPtr] <= rec.taken;
    end
  end

  // head falls through to the outputs
  assign recValid = (occupancy != '0);
  assign recKind = kindMem[rdPtr];
  assign recAddr = addrMem[rdPtr];
  assign recOp = opMem[rdPtr];
  assign recOutcome = outcomeMem[rdPtr];
  assign recTaken = takenMem[rdPtr];

  ////////////////////////////////////////////////////////////
  // pointers, occupancy and drops
  ////////////////////////////////////////////////////////////

  // pointers wrap explicitly so any depth works
  always_ff @(posedge clk) begin
    if (resetEdge) begin
      wrPtr <= '0;
      rdPtr <= '0;
      occupancy <= '0;
    end else begin
      if (doWrite) begin
        wrPtr <= (wrPtr == LAST_PTR) ? '0 : wrPtr + 1'b1;
      end
      if (doRead) begin
        rdPtr <= (rdPtr == LAST_PTR) ? '0 : rdPtr + 1'b1;
      end
      if (doWrite && !doRead) begin
        occupancy <= occupancy + 1'b1;
      end else if (doRead && !doWrite) begin
        occupancy <= occupancy - 1'b1;
      end
    end
  end

  // saturates instead of wrapping back to a small number
  always_ff @(posedge clk) begin
    if (resetEdge) begin
      dropCount <= '0;
    end else if (rec.valid && !doWrite && dropCount != '1) begin
      dropCount <= dropCount + 1'b1;
    end
  end

  noOverfill: assert property (@(posedge clk) disable iff (resetEdge)
      occupancy <= FULL_CNT)
    else $error("trace buffer occupancy above depth");

endmodule

// ==== verilog/traceEncoder.sv ====
// classifies cache accesses and branches and merges them with markers into registered records
`timescale 1ns/100ps

module traceEncoder (
  input logic clk,
  input logic resetEdge,
  input logic trainPulse,
  input logic startPulse,
  input logic endPulse,
  input logic inWindow,
  input logic cacheEn,
  input logic branchEn,
  input logic cfiMode,
  input traceCfgPkg::runTagT runTag,
  input logic cacheAccess,
  input traceCfgPkg::addrT cacheAddr,
  input traceTypesPkg::cacheOpE cacheOp,
  input logic cacheHit,
  input logic cacheAllValid,
  input logic cacheDirty,
  input logic retireValid,
  input traceTypesPkg::instrClassT instrClass,
  input traceCfgPkg::addrT retirePc,
  input logic branchTaken,
  traceRecordIf.src rec
);
  import traceCfgPkg::*;
  import traceTypesPkg::*;

  outcomeE cacheOutcome;
  logic cacheQual;
  logic branchSel;
  logic branchQual;
  addrT markerAddr;

  logic nxtValid;
  recKindE nxtKind;
  addrT nxtAddr;
  cacheOpE nxtOp;
  outcomeE nxtOutcome;
  logic nxtTaken;

  ////////////////////////////////////////////////////////////
  // classification and qualification
  ////////////////////////////////////////////////////////////

  // hit, then empty way, then dirty or clean victim
  always_comb begin
    if (cacheOp == OP_FLUSH) begin
      cacheOutcome = OUT_NONE;
    end else if (cacheHit) begin
      cacheOutcome = OUT_HIT;
    end else if (!cacheAllValid) begin
      cacheOutcome = OUT_MISS;
    end else if (cacheDirty) begin
      cacheOutcome = OUT_EVICT_DIRTY;
    end else begin
      cacheOutcome = OUT_EVICT_CLEAN;
    end
  end

  assign cacheQual = cacheEn & inWindow & cacheAccess;
  // conditional branches only, or any control transfer in cfi mode
  assign branchSel = cfiMode ? (|instrClass) : instrClass[CLASS_COND_BIT];
  assign branchQual = branchEn & inWindow & retireValid & branchSel;
  assign markerAddr = addrT'(runTag);

  ////////////////////////////////////////////////////////////
  // priority merge
  ////////////////////////////////////////////////////////////

  // one record per cycle, losers are discarded without counting
  always_comb begin
    nxtValid = 1'b1;
    nxtKind = REC_TRAIN;
    nxtAddr = '0;
    nxtOp = OP_READ;
    nxtOutcome = OUT_NONE;
    nxtTaken = 1'b0;
    if (trainPulse) begin
      nxtKind = REC_TRAIN;
    end else if (endPulse) begin
      nxtKind = REC_END;
      nxtAddr = markerAddr;
    end else if (startPulse) begin
      nxtKind = REC_BEGIN;
      nxtAddr = markerAddr;
    end else if (cacheQual) begin
      nxtKind = REC_CACHE;
      nxtAddr = cacheAddr;
      nxtOp = cacheOp;
      nxtOutcome = cacheOutcome;
    end else if (branchQual) begin
      nxtKind = REC_BRANCH;
      nxtAddr = retirePc;
      nxtTaken = branchTaken;
    end else begin
      nxtValid = 1'b0;
    end
  end

  // record shows one cycle after its input
  always_ff @(posedge clk) begin
    if (resetEdge) begin
      rec.valid <= 1'b0;
    end else begin
      rec.valid <= nxtValid;
    end
  end

  always_ff @(posedge clk) begin
    rec.kind <= nxtKind;
    rec.addr <= nxtAddr;
    rec.op <= nxtOp;
    rec.outcome <= nxtOutcome;
    rec.taken <= nxtTaken;
  end

  // a stray kind would be queued and read out as garbage
  knownKind: assert property (@(posedge clk) disable iff (resetEdge)
      rec.valid |-> rec.kind inside {REC_TRAIN, REC_BEGIN, REC_END, REC_CACHE, REC_BRANCH})
    else $error("record valid with unknown kind");

endmodule

// ==== verilog/eventCounters.sv ====
// free-running event counters, snapshotted at window start, deltas held from window end
`timescale 1ns/100ps

module eventCounters #(
  parameter int NUM_EVENTS = traceCfgPkg::NUM_EVENTS
) (
  input logic clk,
  input logic resetEdge,
  input logic [NUM_EVENTS-1:0] events,
  input logic startPulse,
  input logic endPulse,
  output traceCfgPkg::countT deltas [NUM_EVENTS]
);
  import traceCfgPkg::*;

  // running count per event line
  countT count [NUM_EVENTS];
  // count as it stood in the start cycle
  countT snap [NUM_EVENTS];

  ////////////////////////////////////////////////////////////
  // one counter, snapshot and delta per event
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_EVENTS; i++) begin : genCounter

    // counts every cycle the event line is high, wraps at 2^32
    always_ff @(posedge clk) begin
      if (resetEdge) begin
        count[i] <= '0;
      end else if (events[i]) begin
        count[i] <= count[i] + 1'b1;
      end
    end

    // start snapshot takes the value before this cycle's event is added
    always_ff @(posedge clk) begin
      if (resetEdge) begin
        snap[i] <= '0;
      end else if (startPulse) begin
        snap[i] <= count[i];
      end
    end

    // delta covers the start cycle up to the cycle before the end cycle
    // the end cycle's own event lands in count one edge later
    always_ff @(posedge clk) begin
      if (resetEdge) begin
        deltas[i] <= '0;
      end else if (endPulse) begin
        deltas[i] <= count[i] - snap[i];
      end
    end

  end

endmodule

// ==== verilog/traceConfig.sv ====
// control and run tag registers and one read port over registers, counter deltas and drops
`timescale 1ns/100ps

module traceConfig #(
  parameter int NUM_EVENTS = traceCfgPkg::NUM_EVENTS
) (
  input logic clk,
  input logic resetEdge,
  input logic cfgWrite,
  input traceCfgPkg::cfgAddrT cfgAddr,
  input traceCfgPkg::countT cfgWdata,
  input traceCfgPkg::countT deltas [NUM_EVENTS],
  input traceCfgPkg::countT dropCount,
  output traceCfgPkg::countT cfgRdata,
  output logic cacheEn,
  output logic branchEn,
  output logic cfiMode,
  output traceCfgPkg::runTagT runTag
);
  import traceCfgPkg::*;

  logic [CTRL_W-1:0] ctrlReg;
  // delta index relative to the counter base, negative below it
  int cntIdx;

  ////////////////////////////////////////////////////////////
  // writable registers
  ////////////////////////////////////////////////////////////

  // tracing starts disabled and the tag starts at zero
  always_ff @(posedge clk) begin
    if (resetEdge) begin
      ctrlReg <= '0;
      runTag <= '0;
    end else if (cfgWrite) begin
      if (cfgAddr == CFG_CTRL) begin
        ctrlReg <= cfgWdata[CTRL_W-1:0];
      end
      if (cfgAddr == CFG_TAG) begin
        runTag <= runTagT'(cfgWdata);
      end
    end
  end

  assign cacheEn = ctrlReg[CTRL_CACHE_EN];
  assign branchEn = ctrlReg[CTRL_BRANCH_EN];
  assign cfiMode = ctrlReg[CTRL_CFI_MODE];

  ////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////

  assign cntIdx = int'(cfgAddr) - int'(CFG_CNT_BASE);

  // unmapped addresses and deltas past NUM_EVENTS read zero
  always_comb begin
    cfgRdata = '0;
    if (cfgAddr == CFG_CTRL) begin
      cfgRdata = countT'(ctrlReg);
    end else if (cfgAddr == CFG_TAG) begin
      cfgRdata = countT'(runTag);
    end else if (cfgAddr == CFG_DROP) begin
      cfgRdata = dropCount;
    end else if (cntIdx >= 0 && cntIdx < NUM_EVENTS) begin
      cfgRdata = deltas[cntIdx];
    end
  end

endmodule

// ==== verilog/sampleWindow.sv ====
// finds the measurement window from trigger levels and marks the first cycle after reset
`timescale 1ns/100ps

module sampleWindow (
  input logic clk,
  input logic resetEdge,
  input logic startTrigger,
  input logic endTrigger,
  output logic startPulse,
  output logic endPulse,
  output logic trainPulse,
  output logic inWindow
);

  logic startD;
  logic endD;
  logic resetD;

  // trigger delays come out of reset high
  // so a trigger already high during reset gives no pulse
  // and no pulse can share the train cycle
  always_ff @(posedge clk) begin
    if (resetEdge) begin
      startD <= 1'b1;
      endD <= 1'b1;
    end else begin
      startD <= startTrigger;
      endD <= endTrigger;
    end
  end

  // plain copy of reset, used only for the falling edge
  always_ff @(posedge clk) begin
    resetD <= resetEdge;
  end

  // rising edges, one cycle each
  assign startPulse = startTrigger & ~startD;
  assign endPulse = endTrigger & ~endD;
  // first cycle with reset low
  assign trainPulse = resetD & ~resetEdge;

  // window level, the end edge wins if both arrive together
  always_ff @(posedge clk) begin
    if (resetEdge) begin
      inWindow <= 1'b0;
    end else if (endPulse) begin
      inWindow <= 1'b0;
    end else if (startPulse) begin
      inWindow <= 1'b1;
    end
  end

  // the encoder would otherwise lose a marker behind TRAIN
  trainAlone: assert property (@(posedge clk) trainPulse |-> !(startPulse || endPulse))
    else $error("start or end pulse in the train cycle");

endmodule

// ==== verilog/traceRecordIf.sv ====
// carries one trace record per cycle from the encoder into the trace buffer, no back-pressure
`timescale 1ns/100ps

interface traceRecordIf;
  import traceCfgPkg::*;
  import traceTypesPkg::*;

  // record present this cycle
  logic valid;
  recKindE kind;
  // cache address, retired pc, or run tag for markers
  addrT addr;
  cacheOpE op;
  outcomeE outcome;
  // branch direction, zero for other kinds
  logic taken;

  // encoder side
  modport src (
    output valid, kind, addr, op, outcome, taken
  );

  // buffer side
  // the buffer takes the record at the edge when valid, or drops it when full
  modport dst (
    input valid, kind, addr, op, outcome, taken
  );

endinterface

// ==== verilog/traceTypesPkg.sv ====
// record kinds, cache access and outcome encodings and instruction class of trace records
package traceTypesPkg;

  ////////////////////////////////////////////////////////////
  // record kinds
  ////////////////////////////////////////////////////////////

  // markers first, then the two kinds of traced events
  typedef enum logic [2:0] {
    REC_TRAIN = 3'd0,
    REC_BEGIN = 3'd1,
    REC_END = 3'd2,
    REC_CACHE = 3'd3,
    REC_BRANCH = 3'd4
  } recKindE;

  ////////////////////////////////////////////////////////////
  // cache access fields
  ////////////////////////////////////////////////////////////

  // operation as presented on the cache access port
  typedef enum logic [1:0] {
    OP_READ = 2'd0,
    OP_WRITE = 2'd1,
    OP_ATOMIC = 2'd2,
    OP_FLUSH = 2'd3
  } cacheOpE;

  // outcome of one access
  // evict clean and evict dirty only happen once every way of the set is valid
  typedef enum logic [2:0] {
    OUT_HIT = 3'd0,
    OUT_MISS = 3'd1,
    OUT_EVICT_CLEAN = 3'd2,
    OUT_EVICT_DIRTY = 3'd3,
    OUT_NONE = 3'd4
  } outcomeE;

  // retired instruction class
  // bit 0 set for a conditional branch, any nonzero value is a control transfer
  typedef logic [1:0] instrClassT;
  localparam int CLASS_COND_BIT = 0;

endpackage

// ==== verilog/traceCfgPkg.sv ====
// widths, default sizes and config register map shared by every block of the trace unit
package traceCfgPkg;

  ////////////////////////////////////////////////////////////
  // widths that carry a meaning
  ////////////////////////////////////////////////////////////

  // physical address of a cache access or pc of a retired instruction
  typedef logic [31:0] addrT;
  // event counter value, also the config data word
  typedef logic [31:0] countT;
  // config register address
  typedef logic [3:0] cfgAddrT;
  // run identifier, begin and end markers carry it in addr
  typedef logic [15:0] runTagT;

  // default sizes, the top level overrides them
  localparam int NUM_EVENTS = 8;
  localparam int TRACE_DEPTH = 16;

  ////////////////////////////////////////////////////////////
  // config register map
  ////////////////////////////////////////////////////////////

  localparam cfgAddrT CFG_CTRL = 4'd0;
  localparam cfgAddrT CFG_TAG = 4'd1;
  // read only
  localparam cfgAddrT CFG_DROP = 4'd2;
  // delta i sits at CFG_CNT_BASE + i
  localparam cfgAddrT CFG_CNT_BASE = 4'd8;

  // bit positions inside CTRL
  localparam int CTRL_CACHE_EN = 0;
  localparam int CTRL_BRANCH_EN = 1;
  localparam int CTRL_CFI_MODE = 2;
  localparam int CTRL_W = 3;

endpackage
